// File: source/rtg_video_pkg.sv
// RTG video package with colour, sync and FIFO word types plus output constants
package rtg_video_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [7:0]  colour_t;     // One colour channel
	typedef logic [15:0] rtg_word_t;   // RGB555 word, bit 15 unused
	typedef logic [3:0]  pix_width_t;  // Clocks per fetch minus one
	typedef logic [6:0]  vb_lines_t;   // Lines of RTG vertical blank

	//////////////////////////////////////////////////
	// Bundled video signals
	//////////////////////////////////////////////////

	// 24-bit colour, red in the top byte
	typedef struct packed {
		colour_t r;  // Red channel
		colour_t g;  // Green channel
		colour_t b;  // Blue channel
	} rgb_t;

	// Chipset syncs, all active low
	typedef struct packed {
		logic cs;  // Composite sync
		logic hs;  // Horizontal sync
		logic vs;  // Vertical sync
	} sync_t;

	// Full chipset video bundle, 27 bits
	typedef struct packed {
		sync_t sync;  // Syncs in the top three bits
		rgb_t  rgb;   // Colour below
	} chip_video_t;

	//////////////////////////////////////////////////
	// RTG vblank state machine
	//////////////////////////////////////////////////

	typedef enum logic {
		VB_COUNT,   // Blanked, counting sync lines
		VB_ACTIVE   // RTG picture visible
	} vblank_state_t;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	localparam int unsigned LEGACY_STROBE_PERIOD = 4;  // Pixel strobe period with RTG off

	// Top two bits of each channel over a set OSD pixel
	localparam logic [1:0] OSD_ON_R = 2'd3;
	localparam logic [1:0] OSD_ON_G = 2'd3;
	localparam logic [1:0] OSD_ON_B = 2'd3;

	// OSD background, a dark blue tint
	localparam logic [1:0] OSD_OFF_R = 2'd0;
	localparam logic [1:0] OSD_OFF_G = 2'd0;
	localparam logic [1:0] OSD_OFF_B = 2'd2;

endpackage

// File: source/rtg_vblank_fsm.sv
// RTG vertical blank timer that holds the screen blank for a set number of lines after vblank
`timescale 1ns/1ps

module rtg_vblank_fsm (
	input  logic                   CLK_114,     // System clock
	input  logic                   rst_n,       // Async reset, active low
	input  logic                   vblank,      // Chipset vblank level
	input  logic                   hs,          // Chipset hsync, active low
	input  rtg_video_pkg::vb_lines_t vb_end,    // Extra blank lines after vblank
	output logic                   rtg_vblank   // RTG screen blank
);

	//////////////////////////////////////////////////
	// State and line counter
	//////////////////////////////////////////////////

	rtg_video_pkg::vblank_state_t state;       // Current state
	rtg_video_pkg::vblank_state_t state_nxt;   // Next state
	rtg_video_pkg::vb_lines_t     line_cnt;    // Sync lines since vblank fell
	rtg_video_pkg::vb_lines_t     line_cnt_nxt;
	logic                         hs_q;        // Registered hsync
	logic                         hs_rise;     // End of a sync pulse

	assign hs_rise = hs & ~hs_q;  // Rising edge against last cycle

	// The host OS makes chipset blanking awkward to reuse, so the
	// RTG blank is counted out here in lines from the chipset vblank
	always_comb begin
		state_nxt    = state;
		line_cnt_nxt = line_cnt;
		case (state)
			rtg_video_pkg::VB_COUNT: begin
				if (vblank) begin
					line_cnt_nxt = '0;                       // Hold at zero in vblank
				end else if (line_cnt == vb_end) begin
					state_nxt = rtg_video_pkg::VB_ACTIVE;    // Compare before increment
				end else if (hs_rise) begin
					line_cnt_nxt = line_cnt + 7'd1;          // One more sync line
				end
			end
			rtg_video_pkg::VB_ACTIVE: begin
				if (vblank) begin
					state_nxt    = rtg_video_pkg::VB_COUNT;  // New frame starts blanking
					line_cnt_nxt = '0;
				end
			end
			default: begin
				state_nxt    = rtg_video_pkg::VB_COUNT;   // Recover to blank
				line_cnt_nxt = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= rtg_video_pkg::VB_COUNT;  // Blank out of reset
			line_cnt <= '0;
			hs_q     <= 1'b1;                     // Idle sync level
		end else begin
			state    <= state_nxt;
			line_cnt <= line_cnt_nxt;
			hs_q     <= hs;
		end
	end

	// Blank in every state but the visible one
	assign rtg_vblank = (state != rtg_video_pkg::VB_ACTIVE);

endmodule

// File: source/rtg_fetch_timer.sv
// Fetch pacer that pops one FIFO word per pixel and exports the pixel strobe
`timescale 1ns/1ps

module rtg_fetch_timer (
	input  logic                    CLK_114,      // System clock
	input  logic                    rst_n,        // Async reset, active low
	input  logic                    rtg_ena,      // RTG screen on
	input  logic                    rtg_blank,    // Combined RTG blank
	input  rtg_video_pkg::pix_width_t pixel_width,  // Clocks per fetch minus one
	output logic                    fifo_rd,      // Pop FIFO head
	output logic                    pixel_stb     // Exported pixel strobe
);

	//////////////////////////////////////////////////
	// RTG fetch pacing
	//////////////////////////////////////////////////

	rtg_video_pkg::pix_width_t pix_ctr;    // Clocks since last fetch
	logic [1:0]                legacy_ctr; // Free-running divider
	logic                      legacy_stb; // Strobe with RTG off

	// Fetch once the counter reaches the programmed width
	assign fifo_rd = rtg_ena & ~rtg_blank & (pix_ctr == pixel_width);

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			pix_ctr <= '0;
		end else if (rtg_blank || fifo_rd) begin
			pix_ctr <= '0;                // Restart pace each blank and fetch
		end else begin
			pix_ctr <= pix_ctr + 4'd1;
		end
	end

	//////////////////////////////////////////////////
	// Legacy pixel strobe
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			legacy_ctr <= '0;
			legacy_stb <= 1'b0;
		end else begin
			legacy_ctr <= legacy_ctr + 2'd1;  // Wraps every four clocks
			legacy_stb <= (legacy_ctr == 2'(rtg_video_pkg::LEGACY_STROBE_PERIOD - 1));
		end
	end

	// Dither logic downstream follows the fetch strobe with RTG on
	assign pixel_stb = rtg_ena ? fifo_rd : legacy_stb;

endmodule

// File: source/video_out_mux.sv
// Video output stage with RGB555 expansion, RTG or chipset select, output register and OSD
`timescale 1ns/1ps

module video_out_mux (
	input  logic                      CLK_114,     // System clock
	input  logic                      rst_n,       // Async reset, active low
	input  logic                      rtg_ena,     // RTG screen on
	input  logic                      rtg_blank,   // Combined RTG blank
	input  rtg_video_pkg::rtg_word_t  fifo_q,      // Current FIFO head
	input  rtg_video_pkg::chip_video_t chip_video, // Chipset syncs and colour
	input  logic                      osd_window,  // Inside OSD area
	input  logic                      osd_pixel,   // OSD foreground pixel
	output rtg_video_pkg::chip_video_t video_out   // Final video
);

	//////////////////////////////////////////////////
	// RGB555 expansion
	//////////////////////////////////////////////////

	// Top bits repeated into the low end so full scale reaches 0xFF
	function automatic rtg_video_pkg::colour_t expand5(input logic [4:0] field);
		return {field, field[4:2]};
	endfunction

	rtg_video_pkg::rgb_t        rtg_rgb;    // Expanded FIFO colour
	rtg_video_pkg::rgb_t        sel_rgb;    // Colour to register
	rtg_video_pkg::chip_video_t video_q;    // Output register
	logic                       rtg_show;   // RTG pixel visible
	logic [1:0]                 osd_r;      // OSD top bits, red
	logic [1:0]                 osd_g;      // OSD top bits, green
	logic [1:0]                 osd_b;      // OSD top bits, blue

	assign rtg_rgb.r = expand5(fifo_q[14:10]);  // Bit 15 dropped
	assign rtg_rgb.g = expand5(fifo_q[9:5]);
	assign rtg_rgb.b = expand5(fifo_q[4:0]);

	//////////////////////////////////////////////////
	// Source select and output register
	//////////////////////////////////////////////////

	assign rtg_show = rtg_ena & ~rtg_blank;          // Chipset colour in blank
	assign sel_rgb  = rtg_show ? rtg_rgb : chip_video.rgb;

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			video_q <= '0;                 // Black, syncs low in reset
		end else begin
			video_q.sync <= chip_video.sync;  // Syncs always straight through
			video_q.rgb  <= sel_rgb;
		end
	end

	//////////////////////////////////////////////////
	// OSD overlay
	//////////////////////////////////////////////////

	// Foreground or background tint per channel
	assign osd_r = osd_pixel ? rtg_video_pkg::OSD_ON_R : rtg_video_pkg::OSD_OFF_R;
	assign osd_g = osd_pixel ? rtg_video_pkg::OSD_ON_G : rtg_video_pkg::OSD_OFF_G;
	assign osd_b = osd_pixel ? rtg_video_pkg::OSD_ON_B : rtg_video_pkg::OSD_OFF_B;

	// Picture shifted down two bits under the OSD so it shows through dimmed
	always_comb begin
		video_out = video_q;
		if (osd_window) begin
			video_out.rgb.r = {osd_r, video_q.rgb.r[7:2]};
			video_out.rgb.g = {osd_g, video_q.rgb.g[7:2]};
			video_out.rgb.b = {osd_b, video_q.rgb.b[7:2]};
		end
	end

endmodule

// File: source/rtg_video_top.sv
// Display output path top level joining RTG vblank timing, fetch pacing and output mux
`timescale 1ns/1ps

module rtg_video_top (
	input  logic                       CLK_114,      // System clock
	input  logic                       rst_n,        // Async reset, active low
	input  rtg_video_pkg::chip_video_t chip_video,   // Chipset video
	input  logic                       hblank,       // Chipset hblank
	input  logic                       vblank,       // Chipset vblank
	input  logic                       rtg_ena,      // RTG screen on
	input  rtg_video_pkg::pix_width_t  pixel_width,  // Clocks per fetch minus one
	input  rtg_video_pkg::vb_lines_t   vb_end,       // RTG vblank length in lines
	input  rtg_video_pkg::rtg_word_t   fifo_q,       // Pixel FIFO head
	input  logic                       osd_window,   // Inside OSD area
	input  logic                       osd_pixel,    // OSD foreground
	output logic                       fifo_rd,      // Pop pixel FIFO
	output logic                       pixel_stb,    // Pixel strobe for dither
	output rtg_video_pkg::chip_video_t video_out     // Final video
);

	//////////////////////////////////////////////////
	// Blanking
	//////////////////////////////////////////////////

	logic rtg_vblank;  // Counted RTG vertical blank
	logic rtg_blank;   // Any RTG blank

	assign rtg_blank = rtg_vblank | hblank;  // Shared by fetch and mux

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	rtg_vblank_fsm i_vblank (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.vblank     (vblank),
		.hs         (chip_video.sync.hs),   // Lines counted on hsync
		.vb_end     (vb_end),
		.rtg_vblank (rtg_vblank)
	);

	rtg_fetch_timer i_fetch (
		.CLK_114     (CLK_114),
		.rst_n       (rst_n),
		.rtg_ena     (rtg_ena),
		.rtg_blank   (rtg_blank),
		.pixel_width (pixel_width),
		.fifo_rd     (fifo_rd),
		.pixel_stb   (pixel_stb)
	);

	video_out_mux i_mux (
		.CLK_114    (CLK_114),
		.rst_n      (rst_n),
		.rtg_ena    (rtg_ena),
		.rtg_blank  (rtg_blank),
		.fifo_q     (fifo_q),               // Head word sampled every clock
		.chip_video (chip_video),
		.osd_window (osd_window),
		.osd_pixel  (osd_pixel),
		.video_out  (video_out)
	);

endmodule

// File: sim/rtg_video_chk.sv
// Assertion checker for fetch strobe and blanking rules of the RTG display path
`timescale 1ns/1ps

module rtg_video_chk (
	input logic CLK_114,    // System clock
	input logic rst_n,      // Async reset, active low
	input logic rtg_ena,    // RTG screen on
	input logic rtg_blank,  // Combined RTG blank
	input logic fifo_rd,    // FIFO pop
	input logic pixel_stb   // Exported pixel strobe
);

	//////////////////////////////////////////////////
	// Fetch rules
	//////////////////////////////////////////////////

	// No pops while the screen is blank
	a_no_rd_in_blank : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		rtg_blank |-> !fifo_rd
	) else $error("fifo_rd high during rtg_blank");

	// Pops are single-cycle pulses
	a_rd_single : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		fifo_rd |=> !fifo_rd
	) else $error("fifo_rd high two cycles in a row");

	//////////////////////////////////////////////////
	// Strobe export
	//////////////////////////////////////////////////

	a_stb_follows_rd : assert property (
		@(posedge CLK_114) disable iff (!rst_n)
		rtg_ena |-> (pixel_stb == fifo_rd)
	) else $error("pixel_stb differs from fifo_rd with RTG on");

endmodule

bind rtg_video_top rtg_video_chk i_chk (
	.CLK_114   (CLK_114),
	.rst_n     (rst_n),
	.rtg_ena   (rtg_ena),
	.rtg_blank (rtg_blank),
	.fifo_rd   (fifo_rd),
	.pixel_stb (pixel_stb)
);

// File: sim/rtg_video_tb.sv
// Table-driven testbench for the RTG display output path with a FIFO model and checks
`timescale 1ns/1ps

module rtg_video_tb;

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                      ena;      // rtg_ena
		rtg_video_pkg::pix_width_t width;    // pixel_width
		rtg_video_pkg::vb_lines_t  vb;       // vb_end
		rtg_video_pkg::rtg_word_t  seed;     // First word at FIFO head
		logic [23:0]               chip;     // Chipset colour
		logic                      osd_w;    // osd_window
		logic                      osd_p;    // osd_pixel
		logic [23:0]               exp_rgb;  // Colour of first visible pixel
		logic [4:0]                period;   // Cycles between strobes
	} row_t;

	localparam int NUM_ROWS   = 7;
	localparam int WAIT_LIMIT = 200;  // Cycles before a wait gives up
	localparam int INTERVALS  = 3;    // Strobe gaps measured per row

	row_t rows [0:NUM_ROWS-1];

	logic                       CLK_114;
	logic                       rst_n;
	rtg_video_pkg::chip_video_t chip_video;
	logic                       hblank;
	logic                       vblank;
	logic                       rtg_ena;
	rtg_video_pkg::pix_width_t  pixel_width;
	rtg_video_pkg::vb_lines_t   vb_end;
	rtg_video_pkg::rtg_word_t   fifo_q;
	logic                       osd_window;
	logic                       osd_pixel;
	logic                       fifo_rd;
	logic                       pixel_stb;
	rtg_video_pkg::chip_video_t video_out;

	int          errors;       // Mismatches over the run
	int          checks;       // Compares over the run
	int          row_errors;   // Mismatches in the current row
	int          i;
	logic        pop_seen;     // fifo_rd seen before the edge

	rtg_video_top i_dut (
		.CLK_114     (CLK_114),
		.rst_n       (rst_n),
		.chip_video  (chip_video),
		.hblank      (hblank),
		.vblank      (vblank),
		.rtg_ena     (rtg_ena),
		.pixel_width (pixel_width),
		.vb_end      (vb_end),
		.fifo_q      (fifo_q),
		.osd_window  (osd_window),
		.osd_pixel   (osd_pixel),
		.fifo_rd     (fifo_rd),
		.pixel_stb   (pixel_stb),
		.video_out   (video_out)
	);

	always #5 CLK_114 = ~CLK_114;  // 10 ns period

	//////////////////////////////////////////////////
	// FIFO model
	//////////////////////////////////////////////////

	always @(negedge CLK_114) pop_seen = fifo_rd;  // Sampled mid cycle

	always @(posedge CLK_114) begin
		if (pop_seen) begin
			#1;
			fifo_q = 16'($urandom);  // Next head after a pop
		end
	end

	//////////////////////////////////////////////////
	// Expected values
	//////////////////////////////////////////////////

	// 5-bit field scaled to 8 bits
	function automatic logic [7:0] widen(input logic [4:0] f);
		return (8'(f) << 3) | (8'(f) >> 2);
	endfunction

	function automatic logic [23:0] rgb555_to_rgb(input logic [15:0] w);
		return {widen(w[14:10]), widen(w[9:5]), widen(w[4:0])};
	endfunction

	// OSD tint in top two bits over the picture shifted down
	function automatic logic [23:0] overlay(input logic [23:0] c, input logic w, input logic p);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = c[23:16];
		g = c[15:8];
		b = c[7:0];
		if (w) begin
			r = {(p ? 2'b11 : 2'b00), r[7:2]};
			g = {(p ? 2'b11 : 2'b00), g[7:2]};
			b = {(p ? 2'b11 : 2'b10), b[7:2]};
		end
		return {r, g, b};
	endfunction

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
			row_errors++;
		end
	endtask

	task automatic drive_slot();
		@(posedge CLK_114);
		#1;  // Inputs change just after the edge
	endtask

	// Counts negedges until the strobe is seen
	task automatic wait_pulse(input bit on_stb, output int n);
		n = 0;
		while (1) begin
			@(negedge CLK_114);
			n++;
			if (!rtg_ena)
				check_value("fifo_rd", 32'(fifo_rd), 32'd0);  // No pops with RTG off
			if (on_stb ? pixel_stb : fifo_rd)
				break;
			if (n >= WAIT_LIMIT) begin
				$display("Timeout: no %s pulse within %0d cycles", on_stb ? "pixel_stb" : "fifo_rd",
					WAIT_LIMIT);
				errors++;
				row_errors++;
				break;
			end
		end
	endtask

	// Drives one sync line and checks fifo_rd and the sync delay
	task automatic hs_line();
		rtg_video_pkg::sync_t prev;
		drive_slot();
		prev = chip_video.sync;
		chip_video.sync.hs = 1'b0;
		@(negedge CLK_114);
		check_value("fifo_rd", 32'(fifo_rd), 32'd0);
		check_value("video_out.sync", 32'(video_out.sync), 32'(prev));  // Old sync still out
		drive_slot();
		@(negedge CLK_114);
		check_value("fifo_rd", 32'(fifo_rd), 32'd0);
		check_value("video_out.sync", 32'(video_out.sync), 32'(chip_video.sync));
		drive_slot();
		chip_video.sync.hs = 1'b1;  // Rising edge counts a line
		drive_slot();
	endtask

	task automatic run_row(input int idx);
		row_t                     r;
		int                       n;
		rtg_video_pkg::rtg_word_t word;
		logic [23:0]              exp;
		r = rows[idx];
		row_errors = 0;
		drive_slot();
		vblank = 1'b1;
		chip_video.sync.vs = 1'b0;
		hblank = 1'b0;
		rtg_ena = r.ena;
		pixel_width = r.width;
		vb_end = r.vb;
		chip_video.rgb = r.chip;
		osd_window = r.osd_w;
		osd_pixel = r.osd_p;
		repeat (4) drive_slot();
		fifo_q = r.seed;            // No pops while blanked
		drive_slot();
		vblank = 1'b0;
		chip_video.sync.vs = 1'b1;
		for (int e = 0; e < int'(r.vb); e++)
			hs_line();

		// First strobe then colour and pacing
		wait_pulse(!r.ena, n);
		@(negedge CLK_114);
		check_value("video_out.rgb", 32'(video_out.rgb), 32'(r.exp_rgb));
		for (int k = 0; k < INTERVALS; k++) begin
			wait_pulse(!r.ena, n);
			check_value("strobe_period", 32'(n + 1), 32'(r.period));
			word = fifo_q;
			@(negedge CLK_114);
			exp = r.ena ? rgb555_to_rgb(word) : r.chip;
			check_value("video_out.rgb", 32'(video_out.rgb), 32'(overlay(exp, r.osd_w, r.osd_p)));
		end

		// hblank shows the chipset colour
		drive_slot();
		hblank = 1'b1;
		@(negedge CLK_114);
		check_value("fifo_rd", 32'(fifo_rd), 32'd0);
		@(negedge CLK_114);
		check_value("video_out.rgb", 32'(video_out.rgb), 32'(overlay(r.chip, r.osd_w, r.osd_p)));
		drive_slot();
		hblank = 1'b0;
		$display("row %0d ena=%0d width=%0d vb_end=%0d done, %0d mismatches", idx, r.ena,
			r.width, r.vb, row_errors);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(28498));
		CLK_114 = 1'b0;
		rst_n = 1'b0;
		chip_video = '{sync: '{cs: 1'b1, hs: 1'b1, vs: 1'b1}, rgb: '0};
		hblank = 1'b0;
		vblank = 1'b1;
		rtg_ena = 1'b0;
		pixel_width = '0;
		vb_end = '0;
		fifo_q = '0;
		osd_window = 1'b0;
		osd_pixel = 1'b0;
		pop_seen = 1'b0;
		errors = 0;
		checks = 0;
		row_errors = 0;

		rows[0] = '{1'b0, 4'd3,  7'd2, 16'h0000, 24'h123456, 1'b0, 1'b0, 24'h123456, 5'd4};
		rows[1] = '{1'b1, 4'd1,  7'd2, 16'h7FFF, 24'h000000, 1'b0, 1'b0, 24'hFFFFFF, 5'd2};
		rows[2] = '{1'b1, 4'd3,  7'd3, 16'h7C00, 24'h00FF00, 1'b0, 1'b0, 24'hFF0000, 5'd4};
		rows[3] = '{1'b1, 4'd7,  7'd1, 16'h4210, 24'h0000FF, 1'b0, 1'b0, 24'h848484, 5'd8};
		rows[4] = '{1'b1, 4'd2,  7'd2, 16'h0000, 24'h445566, 1'b1, 1'b1, 24'hC0C0C0, 5'd3};
		rows[5] = '{1'b0, 4'd5,  7'd2, 16'h0000, 24'hFFFFFF, 1'b1, 1'b0, 24'h3F3FBF, 5'd4};
		rows[6] = '{1'b1, 4'd15, 7'd4, 16'h03E0, 24'h808080, 1'b1, 1'b0, 24'h003F80, 5'd16};

		repeat (8) begin  // Reset held 8 cycles
			@(negedge CLK_114);
			check_value("video_out", 32'(video_out), 32'd0);
			check_value("fifo_rd", 32'(fifo_rd), 32'd0);
			check_value("pixel_stb", 32'(pixel_stb), 32'd0);
		end
		drive_slot();
		rst_n = 1'b1;
		@(negedge CLK_114);
		check_value("video_out", 32'(video_out), 32'd0);
		check_value("fifo_rd", 32'(fifo_rd), 32'd0);
		check_value("pixel_stb", 32'(pixel_stb), 32'd0);
		$display("reset done, %0d mismatches", errors);

		for (i = 0; i < NUM_ROWS; i++)
			run_row(i);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// Guard against a stuck run
	initial begin
		#100000;
		$display("Simulation ran past its time limit");
		$display("Checks failed");
		$finish;
	end

endmodule

// File: verilog.f
source/rtg_video_pkg.sv
source/rtg_vblank_fsm.sv
source/rtg_fetch_timer.sv
source/video_out_mux.sv
source/rtg_video_top.sv
sim/rtg_video_chk.sv
sim/rtg_video_tb.sv

// File: Makefile
# Verilator build and run for the RTG display output path

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = rtg_video_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A nonzero exit or the fail message in the log both count as failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation result: FAILED"; exit 1; \
	else \
		echo "Simulation result: passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
